//--- design/datapath_controller.sv
`timescale 1ns/1ps

module datapath_controller (
    input  rv_isa_pkg::inst_t   i_inst,
    input  logic                i_is_equal,          // rs1 == rs2
    input  logic                i_is_less_signed,    // rs1 < rs2 signed
    input  logic                i_is_less_unsigned,  // rs1 < rs2 unsigned
    output rv_core_pkg::ctrl_t  o_ctrl
);

    always_comb
    begin
        // No-op defaults, also taken by unknown encodings
        o_ctrl.mem_we       = 1'b0;
        o_ctrl.mem_re       = 1'b0;
        o_ctrl.mem_access   = rv_isa_pkg::ACC_WORD;
        o_ctrl.mem_unsigned = 1'b0;
        o_ctrl.pc_sel       = rv_core_pkg::PC_PLUS4;
        o_ctrl.alu_op       = rv_isa_pkg::ALU_ADD;
        o_ctrl.a_sel        = rv_core_pkg::A_REG;
        o_ctrl.b_sel        = rv_core_pkg::B_REG;
        o_ctrl.rd_we        = 1'b0;
        o_ctrl.wb_sel       = rv_core_pkg::WB_ALU;

        unique casez ({i_inst[31:25], i_inst[14:12], i_inst[6:0]})
            {10'b???????_???, rv_isa_pkg::OP_LUI}:
            begin
                o_ctrl.a_sel = rv_core_pkg::A_ZERO;
                o_ctrl.b_sel = rv_core_pkg::B_IMM;
                o_ctrl.rd_we = 1'b1;
            end
            {10'b???????_???, rv_isa_pkg::OP_AUIPC}:
            begin
                o_ctrl.a_sel = rv_core_pkg::A_PC;
                o_ctrl.b_sel = rv_core_pkg::B_IMM;
                o_ctrl.rd_we = 1'b1;
            end
            {10'b???????_???, rv_isa_pkg::OP_JAL}:
            begin
                o_ctrl.wb_sel = rv_core_pkg::WB_PC4;
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.pc_sel = rv_core_pkg::PC_OFFSET;
            end
            {10'b???????_000, rv_isa_pkg::OP_JALR}:
            begin
                o_ctrl.wb_sel = rv_core_pkg::WB_PC4;
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.pc_sel = rv_core_pkg::PC_INDIRECT;
            end
            {10'b???????_000, rv_isa_pkg::OP_BRANCH}:  // BEQ
                if (i_is_equal) o_ctrl.pc_sel = rv_core_pkg::PC_OFFSET;
            {10'b???????_001, rv_isa_pkg::OP_BRANCH}:  // BNE
                if (!i_is_equal) o_ctrl.pc_sel = rv_core_pkg::PC_OFFSET;
            {10'b???????_100, rv_isa_pkg::OP_BRANCH}:  // BLT
                if (i_is_less_signed) o_ctrl.pc_sel = rv_core_pkg::PC_OFFSET;
            {10'b???????_101, rv_isa_pkg::OP_BRANCH}:  // BGE
                if (!i_is_less_signed) o_ctrl.pc_sel = rv_core_pkg::PC_OFFSET;
            {10'b???????_110, rv_isa_pkg::OP_BRANCH}:  // BLTU
                if (i_is_less_unsigned) o_ctrl.pc_sel = rv_core_pkg::PC_OFFSET;
            {10'b???????_111, rv_isa_pkg::OP_BRANCH}:  // BGEU
                if (!i_is_less_unsigned) o_ctrl.pc_sel = rv_core_pkg::PC_OFFSET;
            {10'b???????_000, rv_isa_pkg::OP_LOAD},   // LB
            {10'b???????_001, rv_isa_pkg::OP_LOAD},   // LH
            {10'b???????_010, rv_isa_pkg::OP_LOAD},   // LW
            {10'b???????_100, rv_isa_pkg::OP_LOAD},   // LBU
            {10'b???????_101, rv_isa_pkg::OP_LOAD}:   // LHU
            begin
                o_ctrl.b_sel        = rv_core_pkg::B_IMM;
                o_ctrl.wb_sel       = rv_core_pkg::WB_MEM;
                o_ctrl.rd_we        = 1'b1;
                o_ctrl.mem_re       = 1'b1;
                o_ctrl.mem_unsigned = i_inst[14];
                o_ctrl.mem_access   = rv_isa_pkg::access_e'(i_inst[13:12]);
            end
            {10'b???????_000, rv_isa_pkg::OP_STORE},  // SB
            {10'b???????_001, rv_isa_pkg::OP_STORE},  // SH
            {10'b???????_010, rv_isa_pkg::OP_STORE}:  // SW
            begin
                o_ctrl.b_sel      = rv_core_pkg::B_IMM;
                o_ctrl.mem_we     = 1'b1;
                o_ctrl.mem_access = rv_isa_pkg::access_e'(i_inst[13:12]);
            end
            {10'b???????_000, rv_isa_pkg::OP_IMM},    // ADDI
            {10'b???????_010, rv_isa_pkg::OP_IMM},    // SLTI
            {10'b???????_011, rv_isa_pkg::OP_IMM},    // SLTIU
            {10'b???????_100, rv_isa_pkg::OP_IMM},    // XORI
            {10'b???????_110, rv_isa_pkg::OP_IMM},    // ORI
            {10'b???????_111, rv_isa_pkg::OP_IMM}:    // ANDI
            begin
                o_ctrl.b_sel  = rv_core_pkg::B_IMM;
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.alu_op = rv_isa_pkg::alu_op_e'({1'b0, i_inst[14:12]});
            end
            // Shift immediates carry the SRA flag in bit 30
            {10'b0000000_001, rv_isa_pkg::OP_IMM},    // SLLI
            {10'b0000000_101, rv_isa_pkg::OP_IMM},    // SRLI
            {10'b0100000_101, rv_isa_pkg::OP_IMM}:    // SRAI
            begin
                o_ctrl.b_sel  = rv_core_pkg::B_IMM;
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.alu_op = rv_isa_pkg::alu_op_e'({i_inst[30], i_inst[14:12]});
            end
            {10'b0000000_???, rv_isa_pkg::OP_OP},     // ADD .. AND
            {10'b0100000_000, rv_isa_pkg::OP_OP},     // SUB
            {10'b0100000_101, rv_isa_pkg::OP_OP}:     // SRA
            begin
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.alu_op = rv_isa_pkg::alu_op_e'({i_inst[30], i_inst[14:12]});
            end
            default: ;
        endcase
    end

endmodule

//--- design/exec_unit.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module exec_unit (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_valid,
    output logic                  o_ready,
    input  rv_isa_pkg::inst_t     i_inst,
    output logic                  o_valid,
    input  logic                  i_ready,
    output rv_core_pkg::commit_t  o_commit
);

    localparam int dmem_aw = $clog2(`RV_DMEM_WORDS);

    rv_core_pkg::ctrl_t   ctrl;
    logic                 fire;
    logic                 is_equal, is_less_signed, is_less_unsigned;
    logic [`RV_XLEN-1:0]  pc, pc_plus4, next_pc, imm;
    logic [`RV_XLEN-1:0]  rs1_data, rs2_data, op_a, op_b, alu_result, rd_data;
    logic [`RV_XLEN-1:0]  mem_word, load_shift, load_data, store_data;
    logic [dmem_aw-1:0]   word_idx;
    logic [3:0]           byte_en;
    logic [`RV_XLEN-1:0]  dmem [`RV_DMEM_WORDS];

    assign fire     = i_valid && i_ready;  // Pure pass-through handshake
    assign o_valid  = i_valid;
    assign o_ready  = i_ready;
    assign pc_plus4 = pc + 4;

    datapath_controller datapath_controller_inst (
        .i_inst(i_inst), .i_is_equal(is_equal), .i_is_less_signed(is_less_signed),
        .i_is_less_unsigned(is_less_unsigned), .o_ctrl(ctrl));

    reg_file reg_file_inst (
        .i_clk(i_clk), .i_rst(i_rst), .i_rs1_addr(i_inst[19:15]), .i_rs2_addr(i_inst[24:20]),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .i_we(fire && ctrl.rd_we),
        .i_rd_addr(i_inst[11:7]), .i_rd_data(rd_data));

    rv_alu rv_alu_inst (
        .i_op(ctrl.alu_op), .i_a(op_a), .i_b(op_b), .o_result(alu_result),
        .i_rs1(rs1_data), .i_rs2(rs2_data), .o_is_equal(is_equal),
        .o_is_less_signed(is_less_signed), .o_is_less_unsigned(is_less_unsigned));

    always_comb
    begin
        case (rv_isa_pkg::opcode_e'(i_inst[6:0]))
            rv_isa_pkg::OP_LUI,
            rv_isa_pkg::OP_AUIPC:  imm = {i_inst[31:12], 12'b0};
            rv_isa_pkg::OP_JAL:    imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20],
                                          i_inst[30:21], 1'b0};
            rv_isa_pkg::OP_BRANCH: imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25],
                                          i_inst[11:8], 1'b0};
            rv_isa_pkg::OP_STORE:  imm = {{21{i_inst[31]}}, i_inst[30:25], i_inst[11:7]};
            default:               imm = {{21{i_inst[31]}}, i_inst[30:20]};  // I-type
        endcase

        case (ctrl.a_sel)
            rv_core_pkg::A_REG: op_a = rs1_data;
            rv_core_pkg::A_PC:  op_a = pc;
            default:            op_a = '0;
        endcase

        case (ctrl.b_sel)
            rv_core_pkg::B_REG: op_b = rs2_data;
            rv_core_pkg::B_IMM: op_b = imm;
            default:            op_b = `RV_XLEN'd4;
        endcase

        case (ctrl.pc_sel)
            rv_core_pkg::PC_OFFSET:   next_pc = pc + imm;
            rv_core_pkg::PC_INDIRECT: next_pc = (rs1_data + imm) & ~`RV_XLEN'd1;
            default:                  next_pc = pc_plus4;
        endcase
    end

    // Loads pick the addressed lane then extend
    assign word_idx   = alu_result[dmem_aw+1:2];
    assign mem_word   = dmem[word_idx];
    assign load_shift = mem_word >> {alu_result[1:0], 3'b000};

    always_comb
    begin
        case (ctrl.mem_access)
            rv_isa_pkg::ACC_BYTE:
            begin
                load_data  = {{24{load_shift[7] & !ctrl.mem_unsigned}}, load_shift[7:0]};
                store_data = {24'b0, rs2_data[7:0]};
                byte_en    = 4'b0001 << alu_result[1:0];
            end
            rv_isa_pkg::ACC_HALF:
            begin
                load_data  = {{16{load_shift[15] & !ctrl.mem_unsigned}}, load_shift[15:0]};
                store_data = {16'b0, rs2_data[15:0]};
                byte_en    = 4'b0011 << alu_result[1:0];
            end
            default:
            begin
                load_data  = mem_word;
                store_data = rs2_data;
                byte_en    = 4'b1111;
            end
        endcase

        case (ctrl.wb_sel)
            rv_core_pkg::WB_MEM: rd_data = ctrl.mem_re ? load_data : '0;
            rv_core_pkg::WB_PC4: rd_data = pc_plus4;
            default:             rd_data = alu_result;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (fire && ctrl.mem_we)
        begin
            for (int b = 0; b < 4; b++)
                if (byte_en[b])
                    dmem[word_idx][8*b +: 8] <= store_data[8*(b - alu_result[1:0]) +: 8];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            pc <= `RV_RESET_PC;
        else if (fire)
            pc <= next_pc;  // Stalls with back-pressure
    end

    assign o_commit.pc        = pc;
    assign o_commit.next_pc   = next_pc;
    assign o_commit.rd_we     = ctrl.rd_we;
    assign o_commit.rd        = i_inst[11:7];
    assign o_commit.rd_data   = rd_data;
    assign o_commit.mem_we    = ctrl.mem_we;
    assign o_commit.mem_addr  = alu_result;
    assign o_commit.mem_wdata = store_data;

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst) pc[1:0] == 2'b00);

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module reg_file (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic [$clog2(`RV_NREGS)-1:0] i_rs1_addr,
    input  logic [$clog2(`RV_NREGS)-1:0] i_rs2_addr,
    output logic [`RV_XLEN-1:0]         o_rs1_data,
    output logic [`RV_XLEN-1:0]         o_rs2_data,
    input  logic                        i_we,
    input  logic [$clog2(`RV_NREGS)-1:0] i_rd_addr,
    input  logic [`RV_XLEN-1:0]         i_rd_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    assign o_rs1_data = regs[i_rs1_addr];  // Asynchronous reads
    assign o_rs2_data = regs[i_rs2_addr];

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end
        else if (i_we && (i_rd_addr != '0))  // x0 is hardwired
            regs[i_rd_addr] <= i_rd_data;
    end

    a_x0_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_rs1_addr == '0) |-> (o_rs1_data == '0));

endmodule

//--- design/rv_alu.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_alu (
    input  rv_isa_pkg::alu_op_e  i_op,
    input  logic [`RV_XLEN-1:0]  i_a,
    input  logic [`RV_XLEN-1:0]  i_b,
    output logic [`RV_XLEN-1:0]  o_result,
    input  logic [`RV_XLEN-1:0]  i_rs1,               // Branch compare operands
    input  logic [`RV_XLEN-1:0]  i_rs2,
    output logic                 o_is_equal,
    output logic                 o_is_less_signed,
    output logic                 o_is_less_unsigned
);

    assign o_is_equal         = (i_rs1 == i_rs2);
    assign o_is_less_signed   = ($signed(i_rs1) < $signed(i_rs2));
    assign o_is_less_unsigned = (i_rs1 < i_rs2);

    always_comb
    begin
        case (i_op)
            rv_isa_pkg::ALU_ADD:  o_result = i_a + i_b;
            rv_isa_pkg::ALU_SUB:  o_result = i_a - i_b;
            rv_isa_pkg::ALU_SLL:  o_result = i_a << i_b[4:0];
            rv_isa_pkg::ALU_SLT:  o_result = `RV_XLEN'($signed(i_a) < $signed(i_b));
            rv_isa_pkg::ALU_SLTU: o_result = `RV_XLEN'(i_a < i_b);
            rv_isa_pkg::ALU_XOR:  o_result = i_a ^ i_b;
            rv_isa_pkg::ALU_SRL:  o_result = i_a >> i_b[4:0];
            rv_isa_pkg::ALU_SRA:  o_result = $unsigned($signed(i_a) >>> i_b[4:0]);
            rv_isa_pkg::ALU_OR:   o_result = i_a | i_b;
            rv_isa_pkg::ALU_AND:  o_result = i_a & i_b;
            default:              o_result = '0;
        endcase
    end

    // The decoder only ever emits the ten RV32I codes
    always_comb
    begin
        assert (i_op inside {rv_isa_pkg::ALU_ADD, rv_isa_pkg::ALU_SUB, rv_isa_pkg::ALU_SLL,
                             rv_isa_pkg::ALU_SLT, rv_isa_pkg::ALU_SLTU, rv_isa_pkg::ALU_XOR,
                             rv_isa_pkg::ALU_SRL, rv_isa_pkg::ALU_SRA, rv_isa_pkg::ALU_OR,
                             rv_isa_pkg::ALU_AND})
        else $error("rv_alu: illegal operation %b", i_op);
    end

endmodule

//--- design/rv_core_pkg.sv
`include "rv_settings.svh"

package rv_core_pkg;

    typedef enum logic [1:0] {A_REG = 2'b00, A_PC = 2'b01, A_ZERO = 2'b10} a_sel_e;
    typedef enum logic [1:0] {B_REG = 2'b00, B_IMM = 2'b01, B_FOUR = 2'b10} b_sel_e;
    typedef enum logic [1:0] {WB_ALU = 2'b00, WB_MEM = 2'b01, WB_PC4 = 2'b10} wb_sel_e;

    // Bit 1 of PC_INDIRECT marks the rs1 base
    typedef enum logic [1:0] {
        PC_PLUS4    = 2'b00,
        PC_OFFSET   = 2'b01,
        PC_INDIRECT = 2'b11
    } pc_sel_e;

    typedef struct packed {
        logic                 mem_we;
        logic                 mem_re;
        rv_isa_pkg::access_e  mem_access;
        logic                 mem_unsigned;
        pc_sel_e              pc_sel;
        rv_isa_pkg::alu_op_e  alu_op;
        a_sel_e               a_sel;
        b_sel_e               b_sel;
        logic                 rd_we;
        wb_sel_e              wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  next_pc;
        logic                 rd_we;
        logic [4:0]           rd;
        logic [`RV_XLEN-1:0]  rd_data;
        logic                 mem_we;
        logic [`RV_XLEN-1:0]  mem_addr;
        logic [`RV_XLEN-1:0]  mem_wdata;     // Size masked, low aligned
    } commit_t;

endpackage

//--- design/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_inst_valid,
    output logic                  o_inst_ready,
    input  rv_isa_pkg::inst_t     i_inst,
    output logic                  o_commit_valid,
    input  logic                  i_commit_ready,
    output rv_core_pkg::commit_t  o_commit
);

    logic                  inst_valid, inst_ready;      // Input buffer to execution
    rv_isa_pkg::inst_t     inst;
    logic                  commit_valid, commit_ready;  // Execution to output buffer
    rv_core_pkg::commit_t  commit;

    skid_buffer #(.T(rv_isa_pkg::inst_t)) skid_in_inst (
        .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_inst_valid), .o_ready(o_inst_ready),
        .i_data(i_inst), .o_valid(inst_valid), .i_ready(inst_ready), .o_data(inst));

    exec_unit exec_unit_inst (
        .i_clk(i_clk), .i_rst(i_rst), .i_valid(inst_valid), .o_ready(inst_ready),
        .i_inst(inst), .o_valid(commit_valid), .i_ready(commit_ready), .o_commit(commit));

    skid_buffer #(.T(rv_core_pkg::commit_t)) skid_out_inst (
        .i_clk(i_clk), .i_rst(i_rst), .i_valid(commit_valid), .o_ready(commit_ready),
        .i_data(commit), .o_valid(o_commit_valid), .i_ready(i_commit_ready),
        .o_data(o_commit));

endmodule

//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [31:0] inst_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_OP     = 7'b0110011
    } opcode_e;

    // Encoded as {inst[30], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10
    } access_e;

endpackage

//--- design/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define RV_XLEN 32                 // Data path width
`define RV_NREGS 32                // Architectural registers
`define RV_DMEM_WORDS 64           // Data memory depth in words
`define RV_RESET_PC 32'h0000_0000  // First fetch address

`endif

//--- design/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
    parameter type T = logic
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);

    logic skid_valid;
    T     skid_data;
    logic in_fire;

    assign in_fire = i_valid && o_ready;
    assign o_ready = !skid_valid;  // Low only when both entries are full

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (!o_valid || i_ready)  // Output slot frees up
        begin
            o_valid    <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end
        else if (in_fire)
            skid_valid <= 1'b1;        // Park behind stalled output
    end

    always_ff @(posedge i_clk)
    begin
        if (!o_valid || i_ready)
            o_data <= skid_valid ? skid_data : i_data;
        if (in_fire)
            skid_data <= i_data;
    end

    a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_data)));

endmodule

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_rv_exec_top -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

//--- src.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/datapath_controller.sv
design/rv_alu.sv
design/reg_file.sv
design/skid_buffer.sv
design/exec_unit.sv
design/rv_exec_top.sv
verif/tb_rv_exec_top.sv

//--- verif/tb_rv_exec_top.sv
`timescale 1ns/1ps

module tb_rv_exec_top;

    typedef struct {
        rv_core_pkg::commit_t c;
        int                   test;
    } exp_entry_t;

    logic                  i_clk = 1'b0;
    logic                  i_rst, i_inst_valid, i_commit_ready;
    logic                  o_inst_ready, o_commit_valid;
    rv_isa_pkg::inst_t     i_inst;
    rv_core_pkg::commit_t  o_commit;

    logic [31:0]          imem [$];        // Program, indexed by pc/4
    logic [31:0]          regs [32];
    logic [7:0]           tb_mem [256];
    logic [31:0]          model_pc;
    exp_entry_t           exp_q [$];
    string                test_names [$];
    int                   chk_idx, inflight, errors, bp_mode, cur_test, prog_len;
    logic                 saw_full;

    rv_exec_top rv_exec_top_inst (
        .i_clk(i_clk), .i_rst(i_rst), .i_inst_valid(i_inst_valid), .o_inst_ready(o_inst_ready),
        .i_inst(i_inst), .o_commit_valid(o_commit_valid), .i_commit_ready(i_commit_ready),
        .o_commit(o_commit));

    always #50 i_clk = ~i_clk;

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA reference step: returns the expected commit and updates the model state
    task automatic model_step(input logic [31:0] w, output rv_core_pkg::commit_t c);
        logic [31:0] a, b, addr, immi, imms, immb;
        logic [2:0]  f3;
        logic        tk;
        a    = regs[w[19:15]];
        b    = regs[w[24:20]];
        f3   = w[14:12];
        immi = {{20{w[31]}}, w[31:20]};
        imms = {{20{w[31]}}, w[31:25], w[11:7]};
        immb = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        c = '0;
        c.pc = model_pc;
        c.next_pc = model_pc + 4;
        c.rd = w[11:7];
        case (w[6:0])
            7'b0110111: {c.rd_we, c.rd_data} = {1'b1, w[31:12], 12'b0};
            7'b0010111: {c.rd_we, c.rd_data} = {1'b1, model_pc + {w[31:12], 12'b0}};
            7'b1101111:
            begin
                {c.rd_we, c.rd_data} = {1'b1, model_pc + 32'd4};
                c.next_pc = model_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100111:
                if (f3 == 3'd0)
                begin
                    {c.rd_we, c.rd_data} = {1'b1, model_pc + 32'd4};
                    c.next_pc = (a + immi) & ~32'd1;
                end
            7'b1100011:
            begin
                case (f3)
                    3'd0: tk = (a == b);
                    3'd1: tk = (a != b);
                    3'd4: tk = $signed(a) < $signed(b);
                    3'd5: tk = $signed(a) >= $signed(b);
                    3'd6: tk = a < b;
                    3'd7: tk = a >= b;
                    default: tk = 1'b0;
                endcase
                if (tk) c.next_pc = model_pc + immb;
            end
            7'b0000011:
            begin
                addr = a + immi;
                c.rd_we = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
                case (f3)
                    3'd0: c.rd_data = {{24{tb_mem[addr[7:0]][7]}}, tb_mem[addr[7:0]]};
                    3'd4: c.rd_data = {24'b0, tb_mem[addr[7:0]]};
                    3'd1: c.rd_data = {{16{tb_mem[addr[7:0]+1][7]}}, tb_mem[addr[7:0]+1],
                                       tb_mem[addr[7:0]]};
                    3'd5: c.rd_data = {16'b0, tb_mem[addr[7:0]+1], tb_mem[addr[7:0]]};
                    default: c.rd_data = {tb_mem[addr[7:0]+3], tb_mem[addr[7:0]+2],
                                          tb_mem[addr[7:0]+1], tb_mem[addr[7:0]]};
                endcase
            end
            7'b0100011:
                if (f3 <= 3'd2)
                begin
                    c.mem_we    = 1'b1;
                    c.mem_addr  = a + imms;
                    c.mem_wdata = (f3 == 3'd0) ? {24'b0, b[7:0]} :
                                  (f3 == 3'd1) ? {16'b0, b[15:0]} : b;
                    for (int k = 0; k < (1 << f3); k++)
                        tb_mem[c.mem_addr[7:0] + k] = b[8*k +: 8];
                end
            7'b0010011:
                if ((f3 != 3'd1 && f3 != 3'd5) || w[31:25] == 7'h00 ||
                    (f3 == 3'd5 && w[31:25] == 7'h20))
                    {c.rd_we, c.rd_data} = {1'b1, alu_ref(f3, (f3 == 3'd5) && w[30], a, immi)};
            7'b0110011:
                if (w[31:25] == 7'h00 || (w[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
                    {c.rd_we, c.rd_data} = {1'b1, alu_ref(f3, w[30], a, b)};
            default: ;  // Unknown encodings retire as no-ops
        endcase
        if (c.rd_we && c.rd != 5'd0) regs[c.rd] = c.rd_data;
        model_pc = c.next_pc;
    endtask

    function automatic logic commit_ok(int idx, rv_core_pkg::commit_t a);
        rv_core_pkg::commit_t e;
        if (idx >= exp_q.size()) return 1'b0;
        e = exp_q[idx].c;
        return a.pc == e.pc && a.next_pc == e.next_pc && a.rd_we == e.rd_we &&
               a.mem_we == e.mem_we && (!e.rd_we || (a.rd == e.rd && a.rd_data == e.rd_data)) &&
               (!e.mem_we || (a.mem_addr == e.mem_addr && a.mem_wdata == e.mem_wdata));
    endfunction

    task automatic report_mismatch(int idx, rv_core_pkg::commit_t a);
        rv_core_pkg::commit_t e;
        errors++;
        if (idx >= exp_q.size())
            $display("A commit came out with no instruction outstanding (pc %h)", a.pc);
        else
        begin
            e = exp_q[idx].c;
            $write("[FAIL] %s: expected pc=%h next=%h rd_we=%b rd=%0d data=%h mem_we=%b %h/%h",
                   test_names[exp_q[idx].test], e.pc, e.next_pc, e.rd_we, e.rd, e.rd_data,
                   e.mem_we, e.mem_addr, e.mem_wdata);
            $display(", actual pc=%h next=%h rd_we=%b rd=%0d data=%h mem_we=%b %h/%h",
                     a.pc, a.next_pc, a.rd_we, a.rd, a.rd_data, a.mem_we, a.mem_addr,
                     a.mem_wdata);
        end
    endtask

    a_commit_match: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_commit_valid && i_commit_ready) |-> commit_ok(chk_idx, o_commit))
        else report_mismatch($sampled(chk_idx), $sampled(o_commit));

    // Four in flight fills both buffers
    a_fill_level: assert property (@(posedge i_clk) disable iff (i_rst)
        (inflight >= 4) |-> !o_inst_ready)
        else
        begin
            errors++;
            $display("Input ready stayed high with %0d in flight", $sampled(inflight));
        end

    a_idle_after_reset: assert property (@(posedge i_clk) $fell(i_rst) |-> !o_commit_valid)
        else
        begin
            errors++;
            $display("A commit was valid right after reset");
        end

    always @(posedge i_clk)
    begin
        if (i_rst)
            {chk_idx, inflight} <= '0;
        else
        begin
            chk_idx  <= chk_idx + int'(o_commit_valid && i_commit_ready);
            inflight <= inflight + int'(i_inst_valid && o_inst_ready)
                                 - int'(o_commit_valid && i_commit_ready);
            if (inflight == 4) saw_full <= 1'b1;
        end
    end

    always @(posedge i_clk)
    begin
        #1;
        case (bp_mode)
            0: i_commit_ready = 1'b1;
            1: i_commit_ready = $urandom % 2;
            default: i_commit_ready = 1'b0;  // Full stall
        endcase
    end

    task automatic send(input logic [31:0] w);
        exp_entry_t ent;
        model_step(w, ent.c);
        ent.test = cur_test;
        exp_q.push_back(ent);
        i_inst       = w;
        i_inst_valid = 1'b1;
        while (!o_inst_ready)
        begin
            @(posedge i_clk);
            #1;
        end
        @(posedge i_clk);
        #1;
        i_inst_valid = 1'b0;
    endtask

    task automatic run_test(input string name, input int last);
        int err0;
        err0 = errors;
        cur_test = test_names.size();
        test_names.push_back(name);
        while (model_pc < 4 * last) send(imem[model_pc >> 2]);
        while (chk_idx != exp_q.size())
        begin
            @(posedge i_clk);
            #1;
        end
        $display("%s: %0d errors", name, errors - err0);
    endtask

    initial
    begin
        int ends [6];
        void'($urandom(32'h6a58));
        {i_rst, i_inst_valid, i_inst, i_commit_ready} = {1'b1, 1'b0, 32'h0, 1'b1};
        {errors, bp_mode, saw_full, model_pc} = '0;
        foreach (regs[r]) regs[r] = '0;
        imem.push_back(enc_i(-12'sd7, 0, 0, 1, 7'b0010011));   // Arithmetic
        imem.push_back(enc_i(12'd5, 0, 0, 2, 7'b0010011));
        imem.push_back({20'h12345, 5'd3, 7'b0110111});
        imem.push_back({20'h00001, 5'd4, 7'b0010111});
        for (int f = 0; f < 8; f++) imem.push_back(enc_r(7'h00, 2, 1, f[2:0], 5 + f));
        imem.push_back(enc_r(7'h20, 1, 2, 0, 13));
        imem.push_back(enc_r(7'h20, 2, 1, 5, 14));
        imem.push_back(enc_i(12'd9, 2, 0, 0, 7'b0010011));     // Write to x0
        imem.push_back(enc_r(7'h00, 2, 0, 0, 15));
        ends[0] = imem.size();
        for (int f = 0; f < 8; f++)                            // Each branch taken and not
            if (f != 2 && f != 3)
                for (int t = 0; t < 2; t++)
                begin
                    if (f < 2)                                 // Equal operands on pass two
                        imem.push_back(enc_b(13'd8, 1, (t == 0) ? 5'd2 : 5'd1, f));
                    else
                        imem.push_back((t == ((f == 7) ? 0 : 1)) ? enc_b(13'd8, 1, 2, f)
                                                                 : enc_b(13'd8, 2, 1, f));
                    imem.push_back(enc_i(12'd1, 20, 0, 20, 7'b0010011));
                end
        ends[1] = imem.size();
        imem.push_back({1'b0, 10'd4, 1'b0, 8'd0, 5'd16, 7'b1101111});  // JAL +8
        imem.push_back(enc_i(12'd1, 20, 0, 20, 7'b0010011));
        imem.push_back({20'h0, 5'd17, 7'b0010111});
        imem.push_back(enc_i(12'd13, 17, 0, 18, 7'b1100111));
        imem.push_back(enc_i(12'd1, 20, 0, 20, 7'b0010011));
        imem.push_back(enc_i(12'd0, 18, 0, 19, 7'b0010011));
        ends[2] = imem.size();
        imem.push_back({20'h87654, 5'd21, 7'b0110111});        // Memory
        imem.push_back(enc_i(12'h321, 21, 0, 21, 7'b0010011));
        imem.push_back(enc_i(12'd64, 0, 0, 22, 7'b0010011));
        imem.push_back(enc_s(12'd0, 21, 22, 2));
        imem.push_back(enc_s(12'd4, 1, 22, 0));
        imem.push_back(enc_s(12'd6, 1, 22, 1));
        imem.push_back(enc_i(12'd0, 22, 2, 23, 7'b0000011));
        imem.push_back(enc_i(12'd4, 22, 0, 24, 7'b0000011));
        imem.push_back(enc_i(12'd4, 22, 4, 25, 7'b0000011));
        imem.push_back(enc_i(12'd6, 22, 1, 26, 7'b0000011));
        imem.push_back(enc_i(12'd6, 22, 5, 27, 7'b0000011));
        imem.push_back(enc_i(12'd3, 22, 0, 28, 7'b0000011));
        imem.push_back(enc_i(12'd1, 22, 4, 29, 7'b0000011));
        ends[3] = imem.size();
        for (int k = 0; k < 12; k++) imem.push_back(enc_i(12'd3, 30, 0, 30, 7'b0010011));
        ends[4] = imem.size();
        imem.push_back(32'hFFFF_FFFF);                         // Unknown encodings
        imem.push_back(32'h0000_0000);
        imem.push_back(enc_i(12'd3, 0, 0, 31, 7'b0010011));
        ends[5] = imem.size();
        prog_len = imem.size();

        repeat (5) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        run_test("arith_logic", ends[0]);
        run_test("branches", ends[1]);
        run_test("jumps", ends[2]);
        bp_mode = 1;
        run_test("memory", ends[3]);
        fork
            begin
                bp_mode = 2;
                repeat (10) @(posedge i_clk);
                bp_mode = 1;
            end
            run_test("backpressure_order", ends[4]);
        join
        if (!saw_full)
        begin
            errors++;
            $display("The pipeline never held four instructions under back-pressure");
        end
        bp_mode = 0;
        run_test("unknown_encoding", ends[5]);
        $display("Tests run: %0d, commits checked: %0d, errors: %0d",
                 test_names.size(), chk_idx, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial
    begin
        wait (prog_len > 0);
        repeat (prog_len * 20 + 200) @(posedge i_clk);
        $display("Timeout: the commits did not all arrive in time");
        $display("Test failures found");
        $finish;
    end

endmodule
